//--- src/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// address fields: tag 31..10, set 9..6, word 5..2
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [21:0] tag_t;
	typedef logic [3:0] set_t;

	// one bit per way, one-hot or zero
	typedef logic [3:0] way_mask_t;

	// beat number inside a 16-beat burst
	typedef logic [3:0] beat_t;

	// data array row is {set, quarter-line}
	typedef logic [5:0] sram_addr_t;
	typedef logic [127:0] line_q_t;

	localparam int NUM_WAYS = 4;
	localparam int BURST_BEATS = 16;

	typedef enum logic {
		IDLE,
		REFILL
	} refill_state_t;

endpackage

`default_nettype wire

//--- src/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array import icache_pkg::*; (
	input wire clk,
	input wire rst,
	input wire addr_t lookup_addr,
	output way_mask_t hit_ways,
	input wire fill_en,
	input wire way_mask_t fill_way,
	input wire addr_t fill_addr,
	input wire st_en,
	input wire addr_t st_addr
);

	localparam int NUM_SETS = 1 << $bits(set_t);

	tag_t tags [NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS-1:0] valid [NUM_SETS];

	set_t lookup_set;
	tag_t lookup_tag;
	set_t fill_set;
	tag_t fill_tag;
	set_t st_set;
	tag_t st_tag;
	way_mask_t snoop_hit;

	assign lookup_set = lookup_addr[9:6];
	assign lookup_tag = lookup_addr[31:10];
	assign fill_set = fill_addr[9:6];
	assign fill_tag = fill_addr[31:10];
	assign st_set = st_addr[9:6];
	assign st_tag = st_addr[31:10];

	// all four ways compared in parallel
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_ways[w] = valid[lookup_set][w] && (tags[lookup_set][w] == lookup_tag);
		end
	end

	// a store kills a stored match, and also a line being filled this cycle
	// with the same tag, so the stale copy never becomes visible
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			snoop_hit[w] = st_en && ((tags[st_set][w] == st_tag) ||
				(fill_en && fill_way[w] && (fill_set == st_set) && (fill_tag == st_tag)));
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill_way[w]) begin
					tags[fill_set][w] <= fill_tag;
				end
			end
		end
	end

	// fill first, invalidate last so it wins on the same entry
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				valid[s] <= '0;
			end
		end else begin
			if (fill_en) begin
				valid[fill_set] <= valid[fill_set] | fill_way;
			end
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (snoop_hit[w]) begin
					valid[st_set][w] <= 1'b0;
				end
			end
		end
	end

	// two ways holding the same line would mean a fill missed a hit
	a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_ways));

endmodule

`default_nettype wire

//--- src/icache_data_sram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_sram import icache_pkg::*; (
	input wire clk,
	input wire cen_n,
	input wire wen_n,
	input wire line_q_t bwen_n,
	input wire sram_addr_t addr,
	input wire line_q_t din,
	output line_q_t dout
);

	// 64 rows of a quarter line each
	line_q_t mem [64];

	always_ff @(posedge clk) begin
		if (!cen_n) begin
			if (!wen_n) begin
				// low mask bit means the bit takes din
				mem[addr] <= (mem[addr] & bwen_n) | (din & ~bwen_n);
			end else begin
				// read data shows up the cycle after the request
				dout <= mem[addr];
			end
		end
	end

endmodule

`default_nettype wire

//--- src/icache_refill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill_ctrl import icache_pkg::*; (
	input wire clk,
	input wire rst,
	input wire req_valid,
	input wire addr_t req_addr,
	input wire way_mask_t hit_ways,
	output logic ar_valid,
	input wire ar_ready,
	output addr_t ar_addr,
	input wire r_valid,
	input wire word_t r_data,
	input wire r_last,
	output logic r_ready,
	output logic idle,
	output logic fill_en,
	output way_mask_t fill_way,
	output addr_t fill_addr,
	output way_mask_t wr_cen_n,
	output logic wr_en_n,
	output sram_addr_t wr_row,
	output line_q_t wr_bwen_n,
	output line_q_t wr_din
);

	refill_state_t state;
	refill_state_t state_nxt;
	beat_t beat_cnt;
	way_mask_t victim;
	addr_t miss_addr;
	logic beat;
	logic [1:0] lane;

	assign beat = r_valid && r_ready;
	assign idle = (state == IDLE);

	// request depends only on the lookup, held until accepted
	assign ar_valid = idle && req_valid && (hit_ways == '0);
	assign ar_addr = {req_addr[31:6], 6'b0};
	assign r_ready = (state == REFILL);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (ar_valid && ar_ready) state_nxt = REFILL;
			REFILL: if (beat && r_last) state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// victim rotates while idle and freezes for the whole burst
	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt <= '0;
			victim <= way_mask_t'(1);
		end else if (idle) begin
			beat_cnt <= '0;
			victim <= {victim[NUM_WAYS-2:0], victim[NUM_WAYS-1]};
		end else if (beat) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_valid && ar_ready) begin
			miss_addr <= ar_addr;
		end
	end

	// tag goes in with the last beat
	assign fill_en = beat && r_last;
	assign fill_way = victim;
	assign fill_addr = miss_addr;

	// beat n lands in row {set, n/4}, lane n%4
	assign lane = beat_cnt[1:0];
	assign wr_cen_n = ~(victim & {NUM_WAYS{beat}});
	assign wr_en_n = ~beat;
	assign wr_row = {miss_addr[9:6], beat_cnt[3:2]};
	assign wr_din = {4{r_data}};

	always_comb begin
		wr_bwen_n = '1;
		wr_bwen_n[lane*32 +: 32] = '0;
	end

	// a beat outside a burst would be dropped
	a_no_beat_when_idle: assert property (@(posedge clk) disable iff (rst)
		r_valid |-> (state == REFILL));

	// memory and cache must agree on where the burst ends
	a_last_on_beat15: assert property (@(posedge clk) disable iff (rst)
		beat |-> (r_last == (beat_cnt == beat_t'(BURST_BEATS - 1))));

endmodule

`default_nettype wire

//--- src/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache import icache_pkg::*; (
	input wire clk,
	input wire rst,
	input wire fetch_valid,
	input wire addr_t fetch_addr,
	input wire flush,
	output word_t inst,
	output logic inst_ready,
	output logic hit,
	input wire st_en,
	input wire addr_t st_addr,
	output logic ar_valid,
	input wire ar_ready,
	output addr_t ar_addr,
	input wire r_valid,
	input wire word_t r_data,
	input wire r_last,
	output logic r_ready
);

	way_mask_t hit_ways;
	way_mask_t fill_way;
	way_mask_t wr_cen_n;
	way_mask_t cen_n;
	way_mask_t hit_way_q;
	logic refill_idle;
	logic fill_en;
	logic wr_en_n;
	logic wen_n;
	addr_t fill_addr;
	sram_addr_t wr_row;
	sram_addr_t sram_row;
	line_q_t wr_bwen_n;
	line_q_t wr_din;
	line_q_t sram_dout [NUM_WAYS];
	line_q_t line_sel;
	logic [1:0] word_q;

	icache_tag_array tag_array_i (
		.clk,
		.rst,
		.lookup_addr(fetch_addr),
		.hit_ways,
		.fill_en,
		.fill_way,
		.fill_addr,
		.st_en,
		.st_addr
	);

	icache_refill_ctrl refill_ctrl_i (
		.clk,
		.rst,
		.req_valid(fetch_valid),
		.req_addr(fetch_addr),
		.hit_ways,
		.ar_valid,
		.ar_ready,
		.ar_addr,
		.r_valid,
		.r_data,
		.r_last,
		.r_ready,
		.idle(refill_idle),
		.fill_en,
		.fill_way,
		.fill_addr,
		.wr_cen_n,
		.wr_en_n,
		.wr_row,
		.wr_bwen_n,
		.wr_din
	);

	assign hit = refill_idle && fetch_valid && (hit_ways != '0);

	// idle: read only the hitting way; refill: arrays belong to the burst
	assign cen_n = refill_idle ? ~(hit_ways & {NUM_WAYS{fetch_valid}}) : wr_cen_n;
	assign wen_n = refill_idle ? 1'b1 : wr_en_n;
	assign sram_row = refill_idle ? fetch_addr[9:4] : wr_row;

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		icache_data_sram data_sram_i (
			.clk,
			.cen_n(cen_n[w]),
			.wen_n,
			.bwen_n(wr_bwen_n),
			.addr(sram_row),
			.din(wr_din),
			.dout(sram_dout[w])
		);
	end

	// way and word offset follow the array read by one cycle
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			inst_ready <= 1'b0;
			hit_way_q <= '0;
			word_q <= '0;
		end else begin
			inst_ready <= hit;
			hit_way_q <= hit ? hit_ways : '0;
			word_q <= fetch_addr[3:2];
		end
	end

	always_comb begin
		line_sel = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (hit_way_q[w]) begin
				line_sel = sram_dout[w];
			end
		end
	end

	assign inst = line_sel[word_q*32 +: 32];

endmodule

`default_nettype wire

//--- src/burst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module burst_mem import icache_pkg::*; #(
	parameter int MEM_ADDR_W = 13,
	parameter int MEM_LATENCY = 3
) (
	input wire clk,
	input wire rst,
	input wire ar_valid,
	output logic ar_ready,
	input wire addr_t ar_addr,
	output logic r_valid,
	output word_t r_data,
	output logic r_last,
	input wire r_ready,
	input wire st_en,
	input wire addr_t st_addr,
	input wire word_t st_data
);

	localparam int WORD_IDX_W = MEM_ADDR_W - 2;
	localparam int LINE_IDX_W = MEM_ADDR_W - 6;
	localparam int LAT_W = $clog2(MEM_LATENCY + 1);

	word_t mem [2**WORD_IDX_W];

	logic busy;
	logic [LINE_IDX_W-1:0] line_q;
	logic [LAT_W-1:0] wait_cnt;
	beat_t beat_cnt;

	// one burst at a time
	assign ar_ready = !busy;

	// beats walk the line in order from word 0
	assign r_data = mem[{line_q, beat_cnt}];
	assign r_last = r_valid && (beat_cnt == beat_t'(BURST_BEATS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			r_valid <= 1'b0;
			beat_cnt <= '0;
			wait_cnt <= '0;
		end else if (!busy) begin
			if (ar_valid && ar_ready) begin
				busy <= 1'b1;
				beat_cnt <= '0;
				wait_cnt <= LAT_W'(MEM_LATENCY - 1);
				r_valid <= (MEM_LATENCY == 1);
			end
		end else if (!r_valid) begin
			// first beat lands MEM_LATENCY cycles after acceptance
			wait_cnt <= wait_cnt - 1'b1;
			if (wait_cnt == LAT_W'(1)) begin
				r_valid <= 1'b1;
			end
		end else if (r_ready) begin
			beat_cnt <= beat_cnt + 1'b1;
			if (r_last) begin
				r_valid <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_valid && ar_ready) begin
			line_q <= ar_addr[MEM_ADDR_W-1:6];
		end
	end

	// stores are accepted in any cycle, even mid-burst
	always_ff @(posedge clk) begin
		if (st_en) begin
			mem[st_addr[MEM_ADDR_W-1:2]] <= st_data;
		end
	end

endmodule

`default_nettype wire

//--- src/icache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module icache_subsystem import icache_pkg::*; #(
	parameter int MEM_ADDR_W = 13,
	parameter int MEM_LATENCY = 3
) (
	input wire clk,
	input wire rst,
	input wire fetch_valid,
	input wire addr_t fetch_addr,
	input wire flush,
	output word_t inst,
	output logic inst_ready,
	output logic hit,
	input wire st_en,
	input wire addr_t st_addr,
	input wire word_t st_data
);

	// read channel between cache and memory
	logic ar_valid;
	logic ar_ready;
	addr_t ar_addr;
	logic r_valid;
	word_t r_data;
	logic r_last;
	logic r_ready;

	icache icache_i (
		.clk,
		.rst,
		.fetch_valid,
		.fetch_addr,
		.flush,
		.inst,
		.inst_ready,
		.hit,
		.st_en,
		.st_addr,
		.ar_valid,
		.ar_ready,
		.ar_addr,
		.r_valid,
		.r_data,
		.r_last,
		.r_ready
	);

	// store port feeds the memory and the cache snoop together
	burst_mem #(
		.MEM_ADDR_W(MEM_ADDR_W),
		.MEM_LATENCY(MEM_LATENCY)
	) burst_mem_i (
		.clk,
		.rst,
		.ar_valid,
		.ar_ready,
		.ar_addr,
		.r_valid,
		.r_data,
		.r_last,
		.r_ready,
		.st_en,
		.st_addr,
		.st_data
	);

endmodule

`default_nettype wire

//--- verif/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int TIMEOUT = 100;
	// 8 KB memory seen by the cache, in words
	localparam int MEM_WORDS = 2048;

	// line in set 5 used by most tests, line in set 8 for the reset test
	localparam addr_t LINE_A = 32'h0000_0140;
	localparam addr_t LINE_B = 32'h0000_1a00;
	// five lines of set 3 are this base plus k * 1 KB
	localparam addr_t SET_BASE = 32'h0000_00c0;
	localparam addr_t TAG_STEP = 32'h0000_0400;

	logic clk;
	logic rst;
	logic fetch_valid;
	addr_t fetch_addr;
	logic flush;
	word_t inst;
	logic inst_ready;
	logic hit;
	logic st_en;
	addr_t st_addr;
	word_t st_data;

	// expected memory contents, kept in step with every store
	word_t shadow [MEM_WORDS];
	integer seed;
	int errors;
	int checks;

	icache_subsystem #(
		.MEM_ADDR_W(13),
		.MEM_LATENCY(3)
	) icache_subsystem_i (
		.clk,
		.rst,
		.fetch_valid,
		.fetch_addr,
		.flush,
		.inst,
		.inst_ready,
		.hit,
		.st_en,
		.st_addr,
		.st_data
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// memory wraps at 8 KB, so only bits 12..2 pick the word
	function automatic int word_index(input addr_t addr);
		return int'(addr[12:2]);
	endfunction

	task automatic compare_value(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL time %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic store_word(input addr_t addr, input word_t data);
		@(posedge clk);
		#1;
		st_en = 1'b1;
		st_addr = addr;
		st_data = data;
		@(posedge clk);
		#1;
		st_en = 1'b0;
		shadow[word_index(addr)] = data;
	endtask

	// all 16 words of one line, random contents
	task automatic fill_line(input addr_t base);
		for (int i = 0; i < BURST_BEATS; i++) begin
			store_word(base + addr_t'(i * 4), word_t'($random(seed)));
		end
	endtask

	// hold the request until it hits, then expect the word one cycle later
	task automatic fetch_expect(input addr_t addr, output logic first_hit);
		int cycles;
		@(posedge clk);
		#1;
		fetch_valid = 1'b1;
		fetch_addr = addr;
		cycles = 0;
		@(negedge clk);
		first_hit = hit;
		while (!hit && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		checks++;
		assert (hit) else begin
			errors++;
			$display("no hit for address %h within %0d cycles at time %0t", addr, TIMEOUT, $time);
		end
		// previous cycle had no hit, so ready must still be low here
		compare_value("inst_ready", inst_ready, 0);
		@(posedge clk);
		#1;
		fetch_valid = 1'b0;
		@(negedge clk);
		compare_value("inst_ready", inst_ready, 1);
		compare_value("inst", inst, shadow[word_index(addr)]);
	endtask

	task automatic reset_state();
		logic h;
		@(negedge clk);
		compare_value("inst_ready", inst_ready, 0);
		compare_value("hit", hit, 0);
		// nothing valid yet
		fetch_expect(LINE_B, h);
		compare_value("hit", h, 0);
	endtask

	task automatic miss_then_hit();
		logic h;
		fetch_expect(LINE_A, h);
		compare_value("hit", h, 0);
		// rest of the line came in with the same burst
		for (int i = 1; i < BURST_BEATS; i++) begin
			fetch_expect(LINE_A + addr_t'(i * 4), h);
			compare_value("hit", h, 1);
		end
	endtask

	task automatic set_capacity();
		logic h;
		for (int k = 0; k < 5; k++) begin
			fetch_expect(SET_BASE + addr_t'(k) * TAG_STEP + addr_t'(k * 4), h);
			compare_value("hit", h, 0);
		end
		// five lines in four ways, so some of these refill again
		for (int k = 0; k < 5; k++) begin
			fetch_expect(SET_BASE + addr_t'(k) * TAG_STEP + addr_t'(k * 4 + 8), h);
		end
	endtask

	task automatic store_snoop();
		logic h;
		addr_t addr;
		word_t new_word;
		addr = LINE_A + 32'd20;
		fetch_expect(addr, h);
		compare_value("hit", h, 1);
		new_word = ~shadow[word_index(addr)];
		store_word(addr, new_word);
		// way got invalidated, refill brings the new word
		fetch_expect(addr, h);
		compare_value("hit", h, 0);
	endtask

	task automatic flush_cancels_ready();
		logic h;
		addr_t addr;
		addr = LINE_A + 32'd8;
		@(posedge clk);
		#1;
		fetch_valid = 1'b1;
		fetch_addr = addr;
		flush = 1'b1;
		@(negedge clk);
		compare_value("hit", hit, 1);
		@(posedge clk);
		#1;
		fetch_valid = 1'b0;
		flush = 1'b0;
		@(negedge clk);
		compare_value("inst_ready", inst_ready, 0);
		// plain request afterwards
		fetch_expect(addr, h);
		compare_value("hit", h, 1);
	endtask

	initial begin
		seed = 38;
		errors = 0;
		checks = 0;
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		flush = 1'b0;
		st_en = 1'b0;
		st_addr = '0;
		st_data = '0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		// preload every line the tests fetch
		fill_line(LINE_A);
		fill_line(LINE_B);
		for (int k = 0; k < 5; k++) begin
			fill_line(SET_BASE + addr_t'(k) * TAG_STEP);
		end

		reset_state();
		miss_then_hit();
		set_capacity();
		store_snoop();
		flush_cancels_ready();

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
src/icache_pkg.sv
src/icache_tag_array.sv
src/icache_data_sram.sv
src/icache_refill_ctrl.sv
src/icache.sv
src/burst_mem.sv
src/icache_subsystem.sv
verif/icache_tb.sv
